//--- sources.f
common/uart_string_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
source/frame_tx.sv
source/frame_rx.sv
source/uart_string_top.sv
sim/tb_uart_string.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_uart_string
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_uart_string.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the uart string link
// clock, reset, serial line models,
// test table, check task and report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_uart_string;

	localparam int clk_freq     = 250_000_000;
	localparam int baud_rate    = 31_250_000;
	localparam int clks_per_bit = clk_freq / baud_rate;
	localparam int max_len      = 16;
	localparam int pay_max      = 20;
	localparam int num_tests    = 16;
	localparam int wait_limit   = 5000;
	localparam int line_limit   = 400;
	localparam int quiet_cycles = 200;
	localparam logic [7:0] delim = 8'h26;

	typedef enum logic [2:0] {
		k_tx,
		k_rx,
		k_rx_hold,
		k_rx_busy,
		k_loop
	} kind_t;

	// valid frame, lone head &, lone & in payload, 17-byte payload
	typedef enum logic [1:0] {
		f_valid,
		f_single,
		f_lone,
		f_over
	} form_t;

	typedef struct packed {
		kind_t      kind;
		form_t      form;
		logic [7:0] len;
		logic [1:0] junk;
		logic       expect_frame;
	} test_t;

	logic                 sys_clk;
	logic                 sys_rst_n;
	logic [max_len*8-1:0] tx_string;
	logic [7:0]           tx_length;
	logic                 tx_req;
	logic                 tx_ack;
	logic [max_len*8-1:0] rx_string;
	logic [7:0]           rx_length;
	logic                 rx_req;
	logic                 rx_ack;
	logic                 uart_rx_port;
	logic                 uart_tx_port;
	logic                 line_drv;
	logic                 loopback;

	test_t                tests [num_tests];
	logic [7:0]           pay [pay_max];
	logic [7:0]           seq_q [$];
	logic [7:0]           cap_q [$];
	logic [max_len*8-1:0] held_string;
	logic [7:0]           held_len;
	integer               seed;
	int                   errors;
	int                   passed;
	int                   failed;

	// serial input comes from the line driver or the dut's own output
	assign uart_rx_port = loopback ? uart_tx_port : line_drv;

	always #2 sys_clk = ~sys_clk;

	uart_string_top #(
		.clk_freq  (clk_freq),
		.baud_rate (baud_rate),
		.max_len   (max_len)
	) u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_ack       (tx_ack),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_req       (rx_req),
		.rx_ack       (rx_ack),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string reason);
		$display("timeout: %s", reason);
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// random byte, never the delimiter
	function automatic logic [7:0] gen_byte();
		logic [7:0] b;
		b = 8'($random(seed));
		if (b == delim) begin
			// ascii 'a'
			b = 8'h61;
		end
		return b;
	endfunction

	// byte 0 in bits 7:0, zero past n
	function automatic logic [max_len*8-1:0] pack_payload(input int n);
		logic [max_len*8-1:0] s;
		int i;
		s = '0;
		for (i = 0; i < max_len; i++) begin
			if (i < n) begin
				s[i*8 +: 8] = pay[i];
			end
		end
		return s;
	endfunction

	task automatic fill_payload();
		int i;
		for (i = 0; i < pay_max; i++) begin
			pay[i] = gen_byte();
		end
	endtask

	task automatic build_seq(input form_t form, input int len, input int junk);
		int i;
		seq_q.delete();
		fill_payload();
		for (i = 0; i < junk; i++) begin
			seq_q.push_back(gen_byte());
		end
		seq_q.push_back(delim);
		if (form != f_single) begin
			seq_q.push_back(delim);
		end
		for (i = 0; i < len; i++) begin
			if (form == f_lone && i == 2) begin
				seq_q.push_back(delim);
			end
			seq_q.push_back(pay[i]);
		end
		// every form closes with &&
		seq_q.push_back(delim);
		seq_q.push_back(delim);
		// rejected forms then get & and junk to leave the parser idle
		if (form != f_valid) begin
			seq_q.push_back(delim);
			seq_q.push_back(gen_byte());
		end
	endtask

	task automatic wait_tx_ack(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (tx_ack !== level && n < wait_limit);
		if (tx_ack !== level) begin
			abort_run($sformatf("tx_ack did not go to %0d", level));
		end
	endtask

	task automatic wait_rx_req(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (rx_req !== level && n < wait_limit);
		if (rx_req !== level) begin
			abort_run($sformatf("rx_req did not go to %0d", level));
		end
	endtask

	// one bit time on the receive line
	task automatic drive_bit(input logic v);
		@(posedge sys_clk);
		line_drv <= v;
		repeat (clks_per_bit - 1) @(posedge sys_clk);
	endtask

	task automatic send_seq();
		int i;
		int j;
		for (i = 0; i < seq_q.size(); i++) begin
			drive_bit(1'b0);
			for (j = 0; j < 8; j++) begin
				drive_bit(seq_q[i][j]);
			end
			drive_bit(1'b1);
		end
	endtask

	// line monitor, samples mid-bit on the falling clock edge
	task automatic capture_bytes(input int count);
		logic [7:0] b;
		int k;
		int j;
		int t;
		for (k = 0; k < count; k++) begin
			t = 0;
			do begin
				@(negedge sys_clk);
				t++;
			end while (uart_tx_port !== 1'b0 && t < line_limit);
			if (uart_tx_port !== 1'b0) begin
				abort_run($sformatf("no start bit for byte %0d on uart_tx_port", k));
			end
			repeat (clks_per_bit / 2) @(negedge sys_clk);
			for (j = 0; j < 8; j++) begin
				repeat (clks_per_bit) @(negedge sys_clk);
				b[j] = uart_tx_port;
			end
			repeat (clks_per_bit) @(negedge sys_clk);
			check_value("uart_tx_port stop bit", 128'(uart_tx_port), 128'd1);
			cap_q.push_back(b);
		end
	endtask

	task automatic ack_rx();
		@(posedge sys_clk);
		rx_ack <= 1'b1;
		wait_rx_req(1'b0);
		@(posedge sys_clk);
		rx_ack <= 1'b0;
	endtask

	task automatic run_tx(input int len);
		int n_exp;
		int i;
		logic [7:0] exp_byte;
		logic       line_busy;
		// && + clamped payload + &&
		n_exp = ((len > max_len) ? max_len : len) + 4;
		fill_payload();
		cap_q.delete();
		@(posedge sys_clk);
		tx_string <= pack_payload(max_len);
		tx_length <= 8'(len);
		tx_req    <= 1'b1;
		fork
			capture_bytes(n_exp);
			begin
				wait_tx_ack(1'b1);
				check_value("bytes out at tx_ack", 128'(cap_q.size()), 128'(n_exp));
			end
		join
		for (i = 0; i < n_exp; i++) begin
			if (i < 2 || i >= n_exp - 2) begin
				exp_byte = delim;
			end else begin
				exp_byte = pay[i-2];
			end
			check_value($sformatf("uart_tx_port byte %0d", i), 128'(cap_q[i]),
				128'(exp_byte));
		end
		repeat (5) @(negedge sys_clk);
		check_value("tx_ack while tx_req high", 128'(tx_ack), 128'd1);
		@(posedge sys_clk);
		tx_req <= 1'b0;
		wait_tx_ack(1'b0);
		// nothing more may follow the frame
		line_busy = 1'b0;
		repeat (20 * clks_per_bit) begin
			@(negedge sys_clk);
			if (uart_tx_port !== 1'b1) begin
				line_busy = 1'b1;
			end
		end
		check_value("uart_tx_port low after frame", 128'(line_busy), 128'd0);
	endtask

	task automatic run_rx(input form_t form, input int len, input int junk,
			input logic expect_frame, input kind_t kind);
		build_seq(form, len, junk);
		send_seq();
		if (kind == k_rx_busy) begin
			repeat (quiet_cycles) @(negedge sys_clk);
			check_value("rx_req under back-pressure", 128'(rx_req), 128'd1);
			check_value("rx_string under back-pressure", rx_string, held_string);
			check_value("rx_length under back-pressure", 128'(rx_length),
				128'(held_len));
			ack_rx();
		end else if (expect_frame) begin
			wait_rx_req(1'b1);
			check_value("rx_length", 128'(rx_length), 128'(len));
			check_value("rx_string", rx_string, pack_payload(len));
			if (kind == k_rx_hold) begin
				held_string = pack_payload(len);
				held_len    = 8'(len);
			end else begin
				ack_rx();
			end
		end else begin
			repeat (quiet_cycles) @(negedge sys_clk);
			check_value("rx_req after rejected frame", 128'(rx_req), 128'd0);
		end
	endtask

	task automatic run_loopback(input int len);
		fill_payload();
		@(posedge sys_clk);
		loopback  <= 1'b1;
		tx_string <= pack_payload(len);
		tx_length <= 8'(len);
		tx_req    <= 1'b1;
		wait_rx_req(1'b1);
		check_value("rx_length", 128'(rx_length), 128'(len));
		check_value("rx_string", rx_string, pack_payload(len));
		wait_tx_ack(1'b1);
		@(posedge sys_clk);
		tx_req <= 1'b0;
		wait_tx_ack(1'b0);
		ack_rx();
		@(posedge sys_clk);
		loopback <= 1'b0;
	endtask

	task automatic load_table();
		tests[0]  = '{k_tx,      f_valid,  8'd0,  2'd0, 1'b1};
		tests[1]  = '{k_tx,      f_valid,  8'd1,  2'd0, 1'b1};
		tests[2]  = '{k_tx,      f_valid,  8'd5,  2'd0, 1'b1};
		tests[3]  = '{k_tx,      f_valid,  8'd16, 2'd0, 1'b1};
		// clamped to 16
		tests[4]  = '{k_tx,      f_valid,  8'd20, 2'd0, 1'b1};
		tests[5]  = '{k_rx,      f_valid,  8'd0,  2'd2, 1'b1};
		tests[6]  = '{k_rx,      f_valid,  8'd3,  2'd3, 1'b1};
		tests[7]  = '{k_rx,      f_valid,  8'd16, 2'd1, 1'b1};
		tests[8]  = '{k_rx,      f_single, 8'd4,  2'd0, 1'b0};
		tests[9]  = '{k_rx,      f_lone,   8'd4,  2'd0, 1'b0};
		tests[10] = '{k_rx,      f_over,   8'd17, 2'd0, 1'b0};
		tests[11] = '{k_rx,      f_valid,  8'd5,  2'd0, 1'b1};
		// back-pressure: held, discarded, then received
		tests[12] = '{k_rx_hold, f_valid,  8'd4,  2'd1, 1'b1};
		tests[13] = '{k_rx_busy, f_valid,  8'd6,  2'd0, 1'b0};
		tests[14] = '{k_rx,      f_valid,  8'd7,  2'd0, 1'b1};
		tests[15] = '{k_loop,    f_valid,  8'd10, 2'd0, 1'b1};
	endtask

	initial begin
		int t;
		int errors_before;
		kind_t k;
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		rx_ack    = 1'b0;
		line_drv  = 1'b1;
		loopback  = 1'b0;
		seed      = 68;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		held_string = '0;
		held_len    = '0;
		load_table();
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		check_value("tx_ack", 128'(tx_ack), 128'd0);
		check_value("rx_req", 128'(rx_req), 128'd0);
		check_value("uart_tx_port", 128'(uart_tx_port), 128'd1);
		check_value("rx_length", 128'(rx_length), 128'd0);
		report_test("reset values", 0);
		for (t = 0; t < num_tests; t++) begin
			errors_before = errors;
			k = tests[t].kind;
			case (k)
				k_tx:    run_tx(int'(tests[t].len));
				k_loop:  run_loopback(int'(tests[t].len));
				default: run_rx(tests[t].form, int'(tests[t].len), int'(tests[t].junk),
					tests[t].expect_frame, k);
			endcase
			report_test($sformatf("%0d %s len %0d", t, k.name(), tests[t].len),
				errors_before);
		end
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- source/uart_string_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart string link top level
// framers over byte uart_tx and uart_rx
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module uart_string_top
	import uart_string_pkg::*;
#(
	parameter int clk_freq  = 50_000_000,
	parameter int baud_rate = 115_200,
	parameter int max_len   = 16
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,

	// transmit host port
	input  logic [max_len*8-1:0] tx_string,
	input  logic [len_w-1:0]     tx_length,
	input  logic                 tx_req,
	output logic                 tx_ack,

	// receive host port
	output logic [max_len*8-1:0] rx_string,
	output logic [len_w-1:0]     rx_length,
	output logic                 rx_req,
	input  logic                 rx_ack,

	input  logic                 uart_rx_port,
	output logic                 uart_tx_port
);

	logic [7:0] byte_tx_data;
	logic       byte_tx_start;
	logic       byte_tx_idle;
	logic [7:0] byte_rx_data;
	logic       byte_rx_valid;

	frame_tx #(.max_len(max_len)) u_frame_tx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.tx_string     (tx_string),
		.tx_length     (tx_length),
		.tx_req        (tx_req),
		.tx_ack        (tx_ack),
		.byte_tx_data  (byte_tx_data),
		.byte_tx_start (byte_tx_start),
		.byte_tx_idle  (byte_tx_idle)
	);

	uart_tx #(.clk_freq(clk_freq), .baud_rate(baud_rate)) u_uart_tx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.byte_tx_data  (byte_tx_data),
		.byte_tx_start (byte_tx_start),
		.byte_tx_idle  (byte_tx_idle),
		.uart_tx_port  (uart_tx_port)
	);

	uart_rx #(.clk_freq(clk_freq), .baud_rate(baud_rate)) u_uart_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.uart_rx_port  (uart_rx_port),
		.byte_rx_data  (byte_rx_data),
		.byte_rx_valid (byte_rx_valid)
	);

	frame_rx #(.max_len(max_len)) u_frame_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.byte_rx_data  (byte_rx_data),
		.byte_rx_valid (byte_rx_valid),
		.rx_string     (rx_string),
		.rx_length     (rx_length),
		.rx_req        (rx_req),
		.rx_ack        (rx_ack)
	);

endmodule

//--- source/frame_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive parser
// finds &&payload&&, runs the rx handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module frame_rx
	import uart_string_pkg::*;
#(
	parameter int max_len = 16
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [7:0]           byte_rx_data,
	input  logic                 byte_rx_valid,
	output logic [max_len*8-1:0] rx_string,
	output logic [len_w-1:0]     rx_length,
	output logic                 rx_req,
	input  logic                 rx_ack
);

	frame_rx_state_t      state;
	logic [max_len*8-1:0] work_buf;
	logic [len_w-1:0]     wr_idx;
	logic                 is_delim;
	logic                 buf_full;
	logic                 frame_end;

	assign is_delim  = (byte_rx_data == frame_delim);
	assign buf_full  = (wr_idx == len_w'(max_len));
	assign frame_end = (state == frx_tail2) && byte_rx_valid && is_delim;

	// working buffer, cleared when a payload begins
	always_ff @(posedge sys_clk) begin
		if (state == frx_head2 && byte_rx_valid && is_delim) begin
			work_buf <= '0;
		end else if (state == frx_payload && byte_rx_valid && !is_delim && !buf_full) begin
			work_buf[wr_idx*8 +: 8] <= byte_rx_data;
		end
	end

	// presented string holds until the next complete frame
	always_ff @(posedge sys_clk) begin
		if (frame_end) begin
			rx_string <= work_buf;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= frx_idle;
			wr_idx    <= '0;
			rx_length <= '0;
			rx_req    <= 1'b0;
		end else begin
			case (state)
				frx_idle: begin
					if (byte_rx_valid && is_delim) begin
						state <= frx_head2;
					end
				end
				frx_head2: begin
					if (byte_rx_valid) begin
						wr_idx <= '0;
						state  <= is_delim ? frx_payload : frx_idle;
					end
				end
				frx_payload: begin
					if (byte_rx_valid) begin
						if (is_delim) begin
							state <= frx_tail2;
						end else if (buf_full) begin
							// oversized payload, drop the frame
							state <= frx_idle;
						end else begin
							wr_idx <= wr_idx + 1'b1;
						end
					end
				end
				frx_tail2: begin
					if (frame_end) begin
						rx_length <= wr_idx;
						rx_req    <= 1'b1;
						state     <= frx_present;
					end else if (byte_rx_valid) begin
						// lone & inside the payload
						state <= frx_idle;
					end
				end
				frx_present: begin
					// incoming bytes ignored until the host lets go
					if (rx_ack) begin
						rx_req <= 1'b0;
						state  <= frx_release;
					end
				end
				frx_release: begin
					if (!rx_ack) begin
						state <= frx_idle;
					end
				end
				default: state <= frx_idle;
			endcase
		end
	end

endmodule

//--- source/frame_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transmit framer
// sends &&payload&& and runs the tx handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module frame_tx
	import uart_string_pkg::*;
#(
	parameter int max_len = 16
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [max_len*8-1:0] tx_string,
	input  logic [len_w-1:0]     tx_length,
	input  logic                 tx_req,
	output logic                 tx_ack,
	output logic [7:0]           byte_tx_data,
	output logic                 byte_tx_start,
	input  logic                 byte_tx_idle
);

	frame_tx_state_t      state;
	logic [max_len*8-1:0] tx_buf;
	logic [len_w-1:0]     tx_len;
	logic [len_w-1:0]     byte_idx;
	logic [len_w-1:0]     len_clamped;
	logic                 can_issue;

	assign len_clamped = (tx_length > len_w'(max_len)) ? len_w'(max_len) : tx_length;

	// serializer idle and no start already in flight
	assign can_issue = byte_tx_idle && !byte_tx_start;

	always_ff @(posedge sys_clk) begin
		if (state == ftx_idle && tx_req && !tx_ack) begin
			tx_buf <= tx_string;
		end
	end

	// payload byte in payload state, delimiter otherwise
	always_ff @(posedge sys_clk) begin
		if (can_issue) begin
			if (state == ftx_payload) begin
				byte_tx_data <= tx_buf[byte_idx*8 +: 8];
			end else begin
				byte_tx_data <= frame_delim;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= ftx_idle;
			tx_len        <= '0;
			byte_idx      <= '0;
			byte_tx_start <= 1'b0;
			tx_ack        <= 1'b0;
		end else begin
			byte_tx_start <= 1'b0;
			case (state)
				ftx_idle: begin
					if (tx_req && !tx_ack) begin
						tx_len   <= len_clamped;
						byte_idx <= '0;
						state    <= ftx_head1;
					end
				end
				ftx_head1: if (can_issue) begin
					byte_tx_start <= 1'b1;
					state         <= ftx_head2;
				end
				ftx_head2: if (can_issue) begin
					// empty payload goes straight to the tail
					byte_tx_start <= 1'b1;
					state         <= (tx_len == '0) ? ftx_tail1 : ftx_payload;
				end
				ftx_payload: if (can_issue) begin
					byte_tx_start <= 1'b1;
					byte_idx      <= byte_idx + 1'b1;
					if (byte_idx == tx_len - 1'b1) begin
						state <= ftx_tail1;
					end
				end
				ftx_tail1: if (can_issue) begin
					byte_tx_start <= 1'b1;
					state         <= ftx_tail2;
				end
				ftx_tail2: if (can_issue) begin
					byte_tx_start <= 1'b1;
					state         <= ftx_done;
				end
				ftx_done: if (can_issue) begin
					// last stop bit is out
					tx_ack <= 1'b1;
					state  <= ftx_release;
				end
				ftx_release: if (!tx_req) begin
					tx_ack <= 1'b0;
					state  <= ftx_idle;
				end
				default: state <= ftx_idle;
			endcase
		end
	end

endmodule

//--- uart/uart_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart byte deserializer
// two-flop sync, mid-bit sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module uart_rx
	import uart_string_pkg::*;
#(
	parameter int clk_freq  = 50_000_000,
	parameter int baud_rate = 115_200
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx_port,
	output logic [7:0] byte_rx_data,
	output logic       byte_rx_valid
);

	localparam int clks_per_bit = clk_freq / baud_rate;
	localparam int half_bit = clks_per_bit / 2;
	localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
	localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] half_end = cnt_w'((half_bit > 0) ? half_bit - 1 : 0);

	uart_bit_state_t  state;
	logic [cnt_w-1:0] baud_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift_reg;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic             fall_edge;
	logic             bit_mid;

	// line idles high, so the sync chain resets high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall_edge = rx_prev && !rx_sync;
	assign bit_mid   = (baud_cnt == bit_end);

	// data bits arrive LSB first
	always_ff @(posedge sys_clk) begin
		if (state == bit_data && bit_mid) begin
			shift_reg <= {rx_sync, shift_reg[7:1]};
		end
		if (state == bit_stop && bit_mid && rx_sync) begin
			byte_rx_data <= shift_reg;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= bit_idle;
			baud_cnt      <= '0;
			bit_cnt       <= '0;
			byte_rx_valid <= 1'b0;
		end else begin
			byte_rx_valid <= 1'b0;
			case (state)
				bit_idle: begin
					baud_cnt <= '0;
					if (fall_edge) begin
						state <= bit_start;
					end
				end
				bit_start: begin
					// high at half a bit means a glitch
					if (baud_cnt == half_end) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						state    <= rx_sync ? bit_idle : bit_data;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				bit_data: begin
					if (bit_mid) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= bit_stop;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				bit_stop: begin
					// a low stop bit drops the byte
					if (bit_mid) begin
						baud_cnt      <= '0;
						byte_rx_valid <= rx_sync;
						state         <= bit_idle;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= bit_idle;
			endcase
		end
	end

endmodule

//--- uart/uart_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart byte serializer
// 8N1, LSB first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module uart_tx
	import uart_string_pkg::*;
#(
	parameter int clk_freq  = 50_000_000,
	parameter int baud_rate = 115_200
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_tx_data,
	input  logic       byte_tx_start,
	output logic       byte_tx_idle,
	output logic       uart_tx_port
);

	localparam int clks_per_bit = clk_freq / baud_rate;
	localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
	localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);

	uart_bit_state_t  state;
	logic [cnt_w-1:0] baud_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift_reg;
	logic             bit_done;

	assign bit_done     = (baud_cnt == bit_end);
	assign byte_tx_idle = (state == bit_idle);

	// one bit time per count cycle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			baud_cnt <= '0;
		end else if (state == bit_idle || bit_done) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// byte latched on start, shifted out on each data bit
	always_ff @(posedge sys_clk) begin
		if (state == bit_idle && byte_tx_start) begin
			shift_reg <= byte_tx_data;
		end else if (state == bit_data && bit_done) begin
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= bit_idle;
			bit_cnt      <= '0;
			uart_tx_port <= 1'b1;
		end else begin
			case (state)
				bit_idle: begin
					if (byte_tx_start) begin
						state        <= bit_start;
						uart_tx_port <= 1'b0;
					end
				end
				bit_start: begin
					if (bit_done) begin
						state        <= bit_data;
						bit_cnt      <= '0;
						uart_tx_port <= shift_reg[0];
					end
				end
				bit_data: begin
					if (bit_done) begin
						if (bit_cnt == 3'd7) begin
							state        <= bit_stop;
							uart_tx_port <= 1'b1;
						end else begin
							bit_cnt      <= bit_cnt + 1'b1;
							uart_tx_port <= shift_reg[1];
						end
					end
				end
				bit_stop: begin
					// full stop bit before going idle
					if (bit_done) begin
						state <= bit_idle;
					end
				end
				default: state <= bit_idle;
			endcase
		end
	end

endmodule

//--- common/uart_string_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the uart string link
// frame delimiter, length width and state enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package uart_string_pkg;

	// frames look like &&payload&&
	localparam logic [7:0] frame_delim = 8'h26;

	// width of every length port
	localparam int len_w = 8;

	// byte serializer and deserializer
	typedef enum logic [1:0] {
		bit_idle,
		bit_start,
		bit_data,
		bit_stop
	} uart_bit_state_t;

	// transmit framer
	typedef enum logic [2:0] {
		ftx_idle,
		ftx_head1,
		ftx_head2,
		ftx_payload,
		ftx_tail1,
		ftx_tail2,
		ftx_done,
		ftx_release
	} frame_tx_state_t;

	// receive parser
	typedef enum logic [2:0] {
		frx_idle,
		frx_head2,
		frx_payload,
		frx_tail2,
		frx_present,
		frx_release
	} frame_rx_state_t;

endpackage
